/* design/cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Bank geometry
`define CACHE_WORD_BYTES        4
`define CACHE_LINE_WORDS        4
`define CACHE_LINES             16
`define CACHE_ADDR_WIDTH        12

// Derived data widths
`define CACHE_WORD_WIDTH        (`CACHE_WORD_BYTES * 8)
`define CACHE_LINE_BYTES        (`CACHE_WORD_BYTES * `CACHE_LINE_WORDS)
`define CACHE_LINE_WIDTH        (`CACHE_LINE_WORDS * `CACHE_WORD_WIDTH)

// Word address is {tag, index, wsel}
`define CACHE_WSEL_BITS         $clog2(`CACHE_LINE_WORDS)
`define CACHE_INDEX_BITS        $clog2(`CACHE_LINES)
`define CACHE_LINE_ADDR_WIDTH   (`CACHE_ADDR_WIDTH - `CACHE_WSEL_BITS)
`define CACHE_TAG_BITS          (`CACHE_LINE_ADDR_WIDTH - `CACHE_INDEX_BITS)

`endif

/* design/cache_pkg.sv */
`default_nettype none

`include "cache_config.svh"

package cache_pkg;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } cache_op_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_WRITEBACK,
        S_MEM_READ,
        S_WAIT_FILL,
        S_REPLAY
    } ctrl_state_e;

    typedef struct packed {
        cache_op_e                      op;
        logic [`CACHE_ADDR_WIDTH-1:0]   addr;
        logic [`CACHE_WORD_WIDTH-1:0]   wdata;
        logic [`CACHE_WORD_BYTES-1:0]   byteen;
    } core_req_t;

    typedef struct packed {
        logic [`CACHE_WORD_WIDTH-1:0]   rdata;
    } core_rsp_t;

    // Writeback line toward memory
    typedef struct packed {
        logic [`CACHE_LINE_ADDR_WIDTH-1:0]  line_addr;
        logic [`CACHE_LINE_WIDTH-1:0]       data;
        logic [`CACHE_LINE_BYTES-1:0]       dirtyb;
    } mem_req_t;

    typedef struct packed {
        logic                           valid;
        logic                           write;
        logic                           fill;
        logic [`CACHE_INDEX_BITS-1:0]   index;
        logic [`CACHE_WSEL_BITS-1:0]    wsel;
        logic [`CACHE_WORD_BYTES-1:0]   byteen;
        logic [`CACHE_WORD_WIDTH-1:0]   wword;
        logic [`CACHE_LINE_WIDTH-1:0]   wline;
    } data_acc_t;

endpackage

`default_nettype wire

/* design/cache_data_store.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module cache_data_store (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [`CACHE_INDEX_BITS-1:0]    read_index,
    output logic [`CACHE_LINE_WIDTH-1:0]    read_data,
    output logic [`CACHE_LINE_BYTES-1:0]    read_dirtyb,
    input  logic                            write_enable,
    input  logic                            write_fill,
    input  logic [`CACHE_LINE_BYTES-1:0]    byte_enable,
    input  logic [`CACHE_LINE_WIDTH-1:0]    write_data
);

    logic [`CACHE_LINE_WIDTH-1:0]                       data_mem [`CACHE_LINES];
    logic [`CACHE_LINES-1:0][`CACHE_LINE_BYTES-1:0]     dirty_q;

    assign read_data   = data_mem[read_index];
    assign read_dirtyb = dirty_q[read_index];

    // Byte-granular line write
    always_ff @(posedge clk) begin
        if (write_enable) begin
            for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
                if (byte_enable[b]) begin
                    data_mem[read_index][b*8 +: 8] <= write_data[b*8 +: 8];
                end
            end
        end
    end

    // A fill leaves the line clean, core writes mark their bytes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dirty_q <= '0;
        end else if (write_enable) begin
            if (write_fill) begin
                dirty_q[read_index] <= '0;
            end else begin
                dirty_q[read_index] <= dirty_q[read_index] | byte_enable;
            end
        end
    end

endmodule

`default_nettype wire

/* design/cache_data_access.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module cache_data_access (
    input  logic                            clk,
    input  logic                            arst_n,
    input  cache_pkg::data_acc_t            acc,
    output logic [`CACHE_WORD_WIDTH-1:0]    rword,
    output logic [`CACHE_LINE_WIDTH-1:0]    rline,
    output logic [`CACHE_LINE_BYTES-1:0]    dirtyb
);

    logic [`CACHE_LINE_WORDS-1:0][`CACHE_WORD_BYTES-1:0]    byte_enable;
    logic [`CACHE_LINE_WIDTH-1:0]                           write_data;
    logic                                                   write_enable;
    logic [`CACHE_LINE_WORDS-1:0]                           word_hot;
    logic [`CACHE_WORD_WIDTH-1:0]                           sel_word;

    cache_data_store data_store_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .read_index   (acc.index),
        .read_data    (rline),
        .read_dirtyb  (dirtyb),
        .write_enable (write_enable),
        .write_fill   (acc.fill),
        .byte_enable  (byte_enable),
        .write_data   (write_data)
    );

    assign write_enable = acc.valid && acc.write;

    // One-hot word select
    assign word_hot = {{(`CACHE_LINE_WORDS-1){1'b0}}, 1'b1} << acc.wsel;

    for (genvar i = 0; i < `CACHE_LINE_WORDS; i++) begin : gen_word
        always_comb begin
            if (acc.fill) begin
                byte_enable[i] = '1;
            end else if (word_hot[i]) begin
                byte_enable[i] = acc.byteen;
            end else begin
                byte_enable[i] = '0;
            end
        end

        // Core word goes to every slot, byte enables pick the target
        assign write_data[i*`CACHE_WORD_WIDTH +: `CACHE_WORD_WIDTH] =
            acc.fill ? acc.wline[i*`CACHE_WORD_WIDTH +: `CACHE_WORD_WIDTH] : acc.wword;
    end

    assign sel_word = rline[acc.wsel*`CACHE_WORD_WIDTH +: `CACHE_WORD_WIDTH];

    // Disabled bytes read as zero
    for (genvar b = 0; b < `CACHE_WORD_BYTES; b++) begin : gen_rmask
        assign rword[b*8 +: 8] = sel_word[b*8 +: 8] & {8{acc.byteen[b]}};
    end

endmodule

`default_nettype wire

/* design/cache_tag_store.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module cache_tag_store (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [`CACHE_INDEX_BITS-1:0]    index,
    input  logic [`CACHE_TAG_BITS-1:0]      tag,
    input  logic                            tag_fill,
    output logic                            hit,
    output logic [`CACHE_TAG_BITS-1:0]      victim_tag
);

    logic [`CACHE_TAG_BITS-1:0] tag_mem [`CACHE_LINES];
    logic [`CACHE_LINES-1:0]    valid_q;

    // Stored tag doubles as the writeback address source
    assign victim_tag = tag_mem[index];
    assign hit        = valid_q[index] && (victim_tag == tag);

    always_ff @(posedge clk) begin
        if (tag_fill) begin
            tag_mem[index] <= tag;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (tag_fill) begin
            valid_q[index] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/cache_bank_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module cache_bank_ctrl (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                core_req_valid,
    input  cache_pkg::core_req_t                core_req,
    output logic                                busy,
    output logic                                core_rsp_valid,
    output cache_pkg::core_rsp_t                core_rsp,
    output logic                                mem_write,
    output cache_pkg::mem_req_t                 mem_wb,
    output logic                                mem_read,
    output logic [`CACHE_LINE_ADDR_WIDTH-1:0]   mem_rd_addr,
    input  logic                                mem_fill_valid,
    input  logic [`CACHE_LINE_WIDTH-1:0]        mem_fill_data,
    input  logic                                hit,
    input  logic [`CACHE_TAG_BITS-1:0]          victim_tag,
    output logic                                tag_fill,
    output cache_pkg::data_acc_t                acc,
    input  logic [`CACHE_WORD_WIDTH-1:0]        rword,
    input  logic [`CACHE_LINE_WIDTH-1:0]        rline,
    input  logic [`CACHE_LINE_BYTES-1:0]        dirtyb
);

    import cache_pkg::*;

    ctrl_state_e                    state_q;
    ctrl_state_e                    state_d;
    core_req_t                      req_q;
    logic                           accept;
    logic                           rsp_fire;
    logic [`CACHE_INDEX_BITS-1:0]   req_index;

    assign accept    = (state_q == S_IDLE) && core_req_valid;
    assign req_index = req_q.addr[`CACHE_WSEL_BITS +: `CACHE_INDEX_BITS];

    assign busy      = state_q != S_IDLE;
    assign mem_write = state_q == S_WRITEBACK;
    assign mem_read  = state_q == S_MEM_READ;
    assign tag_fill  = (state_q == S_WAIT_FILL) && mem_fill_valid;

    // Also steers the tag lookup while a miss is in flight
    assign mem_rd_addr = req_q.addr[`CACHE_ADDR_WIDTH-1:`CACHE_WSEL_BITS];

    assign mem_wb.line_addr = {victim_tag, req_index};
    assign mem_wb.data      = rline;
    assign mem_wb.dirtyb    = dirtyb;

    // Hit served on accept, miss answered after the replay
    assign rsp_fire = (accept && hit) || (state_q == S_REPLAY);

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (accept && !hit) begin
                    state_d = (|dirtyb) ? S_WRITEBACK : S_MEM_READ;
                end
            end
            S_WRITEBACK: state_d = S_MEM_READ;
            S_MEM_READ:  state_d = S_WAIT_FILL;
            S_WAIT_FILL: begin
                if (mem_fill_valid) begin
                    state_d = S_REPLAY;
                end
            end
            S_REPLAY:    state_d = S_IDLE;
            default:     state_d = S_IDLE;
        endcase
    end

    always_comb begin
        acc = '0;
        if (state_q == S_IDLE) begin
            acc.valid  = core_req_valid && hit;
            acc.write  = core_req.op == OP_WRITE;
            acc.index  = core_req.addr[`CACHE_WSEL_BITS +: `CACHE_INDEX_BITS];
            acc.wsel   = core_req.addr[`CACHE_WSEL_BITS-1:0];
            acc.byteen = core_req.byteen;
            acc.wword  = core_req.wdata;
        end else if (state_q == S_WAIT_FILL) begin
            acc.valid  = mem_fill_valid;
            acc.write  = 1'b1;
            acc.fill   = 1'b1;
            acc.index  = req_index;
            acc.wline  = mem_fill_data;
        end else begin
            // Victim readout during writeback, latched access on replay
            acc.valid  = state_q == S_REPLAY;
            acc.write  = req_q.op == OP_WRITE;
            acc.index  = req_index;
            acc.wsel   = req_q.addr[`CACHE_WSEL_BITS-1:0];
            acc.byteen = req_q.byteen;
            acc.wword  = req_q.wdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q        <= S_IDLE;
            core_rsp_valid <= 1'b0;
        end else begin
            state_q        <= state_d;
            core_rsp_valid <= rsp_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= core_req;
        end
        if (rsp_fire) begin
            core_rsp.rdata <= acc.write ? '0 : rword;
        end
    end

endmodule

`default_nettype wire

/* design/cache_bank.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module cache_bank (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                core_req_valid,
    input  cache_pkg::core_req_t                core_req,
    output logic                                busy,
    output logic                                core_rsp_valid,
    output cache_pkg::core_rsp_t                core_rsp,
    output logic                                mem_write,
    output cache_pkg::mem_req_t                 mem_wb,
    output logic                                mem_read,
    output logic [`CACHE_LINE_ADDR_WIDTH-1:0]   mem_rd_addr,
    input  logic                                mem_fill_valid,
    input  logic [`CACHE_LINE_WIDTH-1:0]        mem_fill_data
);

    import cache_pkg::*;

    data_acc_t                          acc;
    logic                               hit;
    logic [`CACHE_TAG_BITS-1:0]         victim_tag;
    logic                               tag_fill;
    logic [`CACHE_WORD_WIDTH-1:0]       rword;
    logic [`CACHE_LINE_WIDTH-1:0]       rline;
    logic [`CACHE_LINE_BYTES-1:0]       dirtyb;
    logic [`CACHE_LINE_ADDR_WIDTH-1:0]  lookup_line;
    logic [`CACHE_INDEX_BITS-1:0]       lookup_index;
    logic [`CACHE_TAG_BITS-1:0]         lookup_tag;

    // Latched line address takes over once busy
    assign lookup_line  = busy ? mem_rd_addr
                               : core_req.addr[`CACHE_ADDR_WIDTH-1:`CACHE_WSEL_BITS];
    assign lookup_index = lookup_line[`CACHE_INDEX_BITS-1:0];
    assign lookup_tag   = lookup_line[`CACHE_LINE_ADDR_WIDTH-1 -: `CACHE_TAG_BITS];

    cache_bank_ctrl bank_ctrl_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .busy           (busy),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .mem_write      (mem_write),
        .mem_wb         (mem_wb),
        .mem_read       (mem_read),
        .mem_rd_addr    (mem_rd_addr),
        .mem_fill_valid (mem_fill_valid),
        .mem_fill_data  (mem_fill_data),
        .hit            (hit),
        .victim_tag     (victim_tag),
        .tag_fill       (tag_fill),
        .acc            (acc),
        .rword          (rword),
        .rline          (rline),
        .dirtyb         (dirtyb)
    );

    cache_tag_store tag_store_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .index      (lookup_index),
        .tag        (lookup_tag),
        .tag_fill   (tag_fill),
        .hit        (hit),
        .victim_tag (victim_tag)
    );

    cache_data_access data_access_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .acc    (acc),
        .rword  (rword),
        .rline  (rline),
        .dirtyb (dirtyb)
    );

endmodule

`default_nettype wire

/* sim/tb_cache_bank.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module tb_cache_bank;

    import cache_pkg::*;

    localparam int NUM_REQS   = 300;
    localparam int WAIT_LIMIT = 40;
    localparam int MEM_LINES  = 256;

    typedef logic [`CACHE_LINE_WIDTH-1:0] check_t;

    logic                               clk;
    logic                               arst_n;
    logic                               core_req_valid;
    core_req_t                          core_req;
    logic                               busy;
    logic                               core_rsp_valid;
    core_rsp_t                          core_rsp;
    logic                               mem_write;
    mem_req_t                           mem_wb;
    logic                               mem_read;
    logic [`CACHE_LINE_ADDR_WIDTH-1:0]  mem_rd_addr;
    logic                               mem_fill_valid;
    logic [`CACHE_LINE_WIDTH-1:0]       mem_fill_data;

    // Memory model and reference cache
    logic [`CACHE_LINE_WIDTH-1:0]   mem_lines [MEM_LINES];
    logic [`CACHE_TAG_BITS-1:0]     ref_tag   [`CACHE_LINES];
    logic                           ref_valid [`CACHE_LINES];
    logic [`CACHE_LINE_WIDTH-1:0]   ref_data  [`CACHE_LINES];
    logic [`CACHE_LINE_BYTES-1:0]   ref_dirty [`CACHE_LINES];

    integer seed;
    int     errors;
    int     checks;
    int     hits;
    int     clean_misses;
    int     dirty_misses;
    bit     aborted;
    string  test_name;

    cache_bank cache_bank_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .busy           (busy),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .mem_write      (mem_write),
        .mem_wb         (mem_wb),
        .mem_read       (mem_read),
        .mem_rd_addr    (mem_rd_addr),
        .mem_fill_valid (mem_fill_valid),
        .mem_fill_data  (mem_fill_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string what, input check_t expected, input check_t actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("error %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("%s: %s", test_name, what);
        end
    endtask

    function automatic logic [`CACHE_LINE_WIDTH-1:0] merge_line(
        input logic [`CACHE_LINE_WIDTH-1:0] old_line,
        input logic [`CACHE_LINE_WIDTH-1:0] new_line,
        input logic [`CACHE_LINE_BYTES-1:0] mask
    );
        logic [`CACHE_LINE_WIDTH-1:0] result;
        result = old_line;
        for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
            if (mask[b]) begin
                result[b*8 +: 8] = new_line[b*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic make_req(output core_req_t req);
        logic [31:0] r;
        r = $random(seed);
        req.op     = r[7] ? OP_WRITE : OP_READ;
        // Four tags over eight indexes, so conflicts are frequent
        req.addr   = {2'b00, r[1:0], r[1:0], 1'b0, r[4:2], r[6:5]};
        req.byteen = r[11:8];
        req.wdata  = $random(seed);
    endtask

    // Reference access on a resident line
    task automatic apply_ref(input core_req_t req, output logic [`CACHE_WORD_WIDTH-1:0] rdata);
        logic [`CACHE_INDEX_BITS-1:0] idx;
        int w;
        int p;
        idx   = req.addr[`CACHE_WSEL_BITS +: `CACHE_INDEX_BITS];
        w     = int'(req.addr[`CACHE_WSEL_BITS-1:0]);
        rdata = '0;
        for (int b = 0; b < `CACHE_WORD_BYTES; b++) begin
            p = w * `CACHE_WORD_BYTES + b;
            if (req.byteen[b] && req.op == OP_WRITE) begin
                ref_data[idx][p*8 +: 8] = req.wdata[b*8 +: 8];
                ref_dirty[idx][p] = 1'b1;
            end else if (req.byteen[b]) begin
                rdata[b*8 +: 8] = ref_data[idx][p*8 +: 8];
            end
        end
    endtask

    task automatic do_access(input core_req_t req);
        logic [`CACHE_INDEX_BITS-1:0]       idx;
        logic [`CACHE_TAG_BITS-1:0]         tag;
        logic [`CACHE_LINE_ADDR_WIDTH-1:0]  line_addr;
        logic [`CACHE_WORD_WIDTH-1:0]       exp_rdata;
        logic                               exp_hit;
        logic                               exp_wb;
        int cycle;
        int write_cycle;
        int read_cycle;
        int fill_delay;
        idx       = req.addr[`CACHE_WSEL_BITS +: `CACHE_INDEX_BITS];
        tag       = req.addr[`CACHE_ADDR_WIDTH-1 -: `CACHE_TAG_BITS];
        line_addr = req.addr[`CACHE_ADDR_WIDTH-1:`CACHE_WSEL_BITS];
        exp_hit   = ref_valid[idx] && (ref_tag[idx] == tag);
        exp_wb    = !exp_hit && (|ref_dirty[idx]);

        @(posedge clk);
        #1;
        check_value("busy before request", check_t'(1'b0), check_t'(busy));
        core_req_valid = 1'b1;
        core_req       = req;
        @(posedge clk);
        #1;
        core_req_valid = 1'b0;
        core_req       = '0;

        if (exp_hit) begin
            apply_ref(req, exp_rdata);
            @(negedge clk);
            if (core_rsp_valid && !busy) begin
                hits++;
            end
            check_value("hit response valid", check_t'(1'b1), check_t'(core_rsp_valid));
            check_value("rdata", check_t'(exp_rdata), check_t'(core_rsp.rdata));
            check_value("busy on hit", check_t'(1'b0), check_t'(busy));
            check_value("mem_read on hit", check_t'(1'b0), check_t'(mem_read));
            check_value("mem_write on hit", check_t'(1'b0), check_t'(mem_write));
        end else begin
            cycle       = 0;
            write_cycle = 0;
            read_cycle  = 0;
            while (read_cycle == 0 && cycle < WAIT_LIMIT) begin
                @(negedge clk);
                cycle++;
                if (cycle == 1) begin
                    check_value("busy after miss", check_t'(1'b1), check_t'(busy));
                end
                if (mem_write) begin
                    write_cycle = cycle;
                    check_value("writeback line address", check_t'({ref_tag[idx], idx}),
                                check_t'(mem_wb.line_addr));
                    check_value("writeback data", ref_data[idx], mem_wb.data);
                    check_value("writeback dirty mask", check_t'(ref_dirty[idx]),
                                check_t'(mem_wb.dirtyb));
                    mem_lines[mem_wb.line_addr[7:0]] =
                        merge_line(mem_lines[mem_wb.line_addr[7:0]], mem_wb.data, mem_wb.dirtyb);
                end
                if (mem_read) begin
                    read_cycle = cycle;
                end
            end
            check_true(read_cycle != 0, "mem_read did not arrive within the timeout");
            if (read_cycle == 0) begin
                aborted = 1'b1;
            end else begin
                if (write_cycle != 0) begin
                    dirty_misses++;
                end else begin
                    clean_misses++;
                end
                check_value("mem_write cycle", check_t'(exp_wb ? 1 : 0), check_t'(write_cycle));
                check_value("mem_read cycle", check_t'(exp_wb ? 2 : 1), check_t'(read_cycle));
                check_value("memory read line address", check_t'(line_addr), check_t'(mem_rd_addr));

                fill_delay = 1 + ($unsigned($random(seed)) % 6);
                repeat (fill_delay) @(posedge clk);
                #1;
                mem_fill_valid = 1'b1;
                mem_fill_data  = mem_lines[mem_rd_addr[7:0]];
                @(posedge clk);
                #1;
                mem_fill_valid = 1'b0;
                mem_fill_data  = '0;

                ref_tag[idx]   = tag;
                ref_valid[idx] = 1'b1;
                ref_data[idx]  = mem_lines[line_addr[7:0]];
                ref_dirty[idx] = '0;
                apply_ref(req, exp_rdata);

                cycle = 0;
                while (!core_rsp_valid && cycle < WAIT_LIMIT) begin
                    @(negedge clk);
                    cycle++;
                end
                check_true(core_rsp_valid, "no response arrived after the fill");
                if (!core_rsp_valid) begin
                    aborted = 1'b1;
                end else begin
                    check_value("response cycle after fill", check_t'(2), check_t'(cycle));
                    check_value("rdata", check_t'(exp_rdata), check_t'(core_rsp.rdata));
                    check_value("busy with response", check_t'(1'b0), check_t'(busy));
                end
            end
        end
    endtask

    initial begin
        core_req_t req;
        seed           = 32'h2075;
        errors         = 0;
        checks         = 0;
        hits           = 0;
        clean_misses   = 0;
        dirty_misses   = 0;
        aborted        = 1'b0;
        arst_n         = 1'b0;
        core_req_valid = 1'b0;
        core_req       = '0;
        mem_fill_valid = 1'b0;
        mem_fill_data  = '0;
        for (int l = 0; l < MEM_LINES; l++) begin
            mem_lines[l] = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
        for (int i = 0; i < `CACHE_LINES; i++) begin
            ref_valid[i] = 1'b0;
            ref_dirty[i] = '0;
        end

        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        test_name = "reset";
        check_value("busy", check_t'(1'b0), check_t'(busy));
        check_value("core_rsp_valid", check_t'(1'b0), check_t'(core_rsp_valid));
        check_value("mem_read", check_t'(1'b0), check_t'(mem_read));
        check_value("mem_write", check_t'(1'b0), check_t'(mem_write));

        test_name = "first read";
        make_req(req);
        req.op = OP_READ;
        do_access(req);

        for (int n = 0; n < NUM_REQS && !aborted; n++) begin
            make_req(req);
            test_name = $sformatf("request %0d", n);
            do_access(req);
            if (req.op == OP_WRITE && !aborted) begin
                // Whole-word readback of the merged write
                req.op     = OP_READ;
                req.byteen = '1;
                test_name  = $sformatf("readback %0d", n);
                do_access(req);
            end
        end

        test_name = "coverage";
        check_true(hits > 0, "the run produced no hit");
        check_true(clean_misses > 0, "the run produced no clean miss");
        check_true(dirty_misses > 0, "the run produced no dirty eviction");

        $display("%0d errors in %0d checks, %0d hits, %0d clean misses, %0d dirty misses",
                 errors, checks, hits, clean_misses, dirty_misses);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+design
design/cache_pkg.sv
design/cache_data_store.sv
design/cache_data_access.sv
design/cache_tag_store.sv
design/cache_bank_ctrl.sv
design/cache_bank.sv
sim/tb_cache_bank.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the cache bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f build.f --top-module tb_cache_bank \
    --Mdir "$BUILD_DIR" -o tb_cache_bank
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_cache_bank" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Checks failed" "$LOG_FILE"; then
    exit 1
fi
exit 0
